// ==== bpu_frontend.f ====
+incdir+tb
source/bpu_pkg.sv
source/pred_table.sv
source/bpu.sv
source/fetch_ctrl.sv
source/bpu_frontend.sv
tb/bpu_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module bpu_frontend_tb \
   -f bpu_frontend.f \
   -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "Build failed with status $status"
   exit 1
fi

./obj_dir/Vbpu_frontend_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/bpu_frontend_tests.svh ====
// Directed tests, included in the testbench module. They rely on its model,
// its monitor and a continuously running fetch stream.

task automatic end_test(string name, int errs_before);
   tests_run++;
   if (errors == errs_before)
      $display("%s: ok", name);
   else
   begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errs_before);
   end
endtask

task automatic wait_accept(output pc_t pc, output logic [W-1:0] sv, output pc_t npc,
                           output bpu_upd_t [W-1:0] upd);
   int n;
   n = 0;
   @(posedge clk);
   while (!(out_valid && out_ready) && n < ACCEPT_LIMIT)
   begin
      @(posedge clk);
      n++;
   end
   if (n >= ACCEPT_LIMIT)
      complain("no bundle accepted within the time limit");
   pc  = out_pc;
   sv  = out_slot_valid;
   npc = out_npc;
   upd = out_upd;
endtask

// One write-back record, held for a single cycle
task automatic send_wb(input wb_rec_t r);
   @(posedge clk);
   wb_valid <= 1'b1;
   wb       <= r;
   @(posedge clk);
   wb_valid <= 1'b0;
   wb       <= '0;
endtask

task automatic compare_tables();
   for (int i = 0; i < (1 << PHT_AW); i++)
      check_value($sformatf("pht[%0d]", i), 64'(pht_m[i]), 64'(dut0.bpu0.pht0.mem[i]));
   for (int i = 0; i < (1 << BTB_AW); i++)
      check_value($sformatf("btb[%0d]", i), 64'(btb_m[i]), 64'(dut0.bpu0.btb0.mem[i]));
   check_value("ghsr", 64'(ghsr_m), 64'(dut0.bpu0.ghsr));
endtask

task automatic reset_stream();
   int               e0;
   pc_t              pc;
   pc_t              npc;
   logic [W-1:0]     sv;
   bpu_upd_t [W-1:0] upd;
   e0 = errors;
   for (int k = 0; k < 4; k++)
   begin
      wait_accept(pc, sv, npc, upd);
      check_value("out_pc", 64'(RESET_PC + pc_t'(k * W)), 64'(pc));
      check_value("out_slot_valid", 64'({W{1'b1}}), 64'(sv));
      check_value("out_npc", 64'(RESET_PC + pc_t'((k + 1) * W)), 64'(npc));
      for (int i = 0; i < W; i++)
         check_value("out_upd.taken", 64'(0), 64'(upd[i].taken));
   end
   end_test("reset stream", e0);
endtask

task automatic btb_redirect();
   int               e0;
   pc_t              x;
   pc_t              t;
   pc_t              pc;
   pc_t              npc;
   logic [W-1:0]     sv;
   logic [W-1:0]     m;
   bpu_upd_t [W-1:0] upd;
   wb_rec_t          r;
   e0 = errors;
   x = pc_t'(next_rand()) & ~OFF_MASK;
   t = pc_t'(next_rand()) | pc_t'(1);
   r = '0;
   r.is_brel = 1'b1;
   r.pc      = x;
   r.npc_act = t;
   send_wb(r);
   r = '0;
   r.mispredict = 1'b1;
   r.npc_act    = x;
   send_wb(r);
   // Branch sits in slot 0, so later slots drop out
   wait_accept(pc, sv, npc, upd);
   check_value("out_pc", 64'(x), 64'(pc));
   check_value("out_slot_valid", 64'(1), 64'(sv));
   check_value("out_npc", 64'(t), 64'(npc));
   wait_accept(pc, sv, npc, upd);
   m = '1;
   m = m << (t & OFF_MASK);
   check_value("out_pc", 64'(t & ~OFF_MASK), 64'(pc));
   check_value("out_slot_valid", 64'(m), 64'(sv));
   end_test("btb redirect", e0);
endtask

task automatic counter_saturation();
   int               e0;
   pc_t              c;
   pc_t              t;
   pc_t              pc;
   pc_t              npc;
   logic [W-1:0]     sv;
   bpu_upd_t [W-1:0] upd;
   bpu_upd_t         u;
   wb_rec_t          r;
   pht_cnt_t         ec;
   logic             etk;
   e0 = errors;
   c = (pc_t'(next_rand()) & ~OFF_MASK) | OFF_MASK;
   t = pc_t'(next_rand());
   r = '0;
   r.is_bcc  = 1'b1;
   r.is_brel = 1'b1;
   r.taken   = 1'b1;
   r.pc      = c;
   r.npc_act = t;
   send_wb(r);
   r = '0;
   r.mispredict = 1'b1;
   r.npc_act    = c & ~OFF_MASK;
   send_wb(r);
   for (int k = 0; k < 24; k++)
   begin
      // Model state is settled here and matches the next lookup
      @(negedge clk);
      ec  = pht_m[c[PHT_AW-1:0] ^ ghsr_m];
      etk = ec[1];
      wait_accept(pc, sv, npc, upd);
      u = upd[W-1];
      check_value("out_pc", 64'(c & ~OFF_MASK), 64'(pc));
      check_value("out_upd.cnt", 64'(ec), 64'(u.cnt));
      check_value("out_upd.taken", 64'(etk), 64'(u.taken));
      check_value("out_npc", 64'(etk ? t : (c & ~OFF_MASK) + pc_t'(W)), 64'(npc));
      // History settles after 8 outcomes, then one counter saturates
      if (k == 11)
         check_value("saturated counter", 64'(2'b11), 64'(u.cnt));
      if (k == 23)
         check_value("saturated counter", 64'(2'b00), 64'(u.cnt));
      r = '0;
      r.is_bcc     = 1'b1;
      r.taken      = (k < 12);
      r.pc         = c;
      r.npc_act    = c & ~OFF_MASK;
      r.mispredict = 1'b1;
      r.upd        = u;
      send_wb(r);
   end
   @(negedge clk);
   compare_tables();
   end_test("counter saturation", e0);
endtask

task automatic mispredict_restart();
   int               e0;
   pc_t              n;
   pc_t              pc;
   pc_t              npc;
   logic [W-1:0]     sv;
   logic [W-1:0]     m;
   bpu_upd_t [W-1:0] upd;
   wb_rec_t          r;
   e0 = errors;
   n = pc_t'(next_rand());
   r = '0;
   r.mispredict = 1'b1;
   r.npc_act    = n;
   send_wb(r);
   wait_accept(pc, sv, npc, upd);
   m = '1;
   m = m << (n & OFF_MASK);
   check_value("out_pc", 64'(n & ~OFF_MASK), 64'(pc));
   check_value("out_slot_valid", 64'(m), 64'(sv));
   end_test("mispredict restart", e0);
endtask

task automatic random_stall();
   int          e0;
   int          a0;
   logic [31:0] r;
   e0 = errors;
   a0 = accept_cnt;
   repeat (200)
   begin
      @(posedge clk);
      r = next_rand();
      out_ready <= r[0];
   end
   @(posedge clk);
   out_ready <= 1'b1;
   if (accept_cnt == a0)
      complain("no bundle accepted under random back-pressure");
   end_test("random stall", e0);
endtask

task automatic upd_echo();
   int               e0;
   pc_t              pc;
   pc_t              npc;
   pc_t              bp;
   logic [W-1:0]     sv;
   bpu_upd_t [W-1:0] upd;
   pht_idx_t         pidx;
   pht_cnt_t         ec;
   wb_rec_t          r;
   e0 = errors;
   wait_accept(pc, sv, npc, upd);
   // No conditional write-back since the lookup, so the model still holds its state
   bp   = pc + pc_t'(W - 1);
   pidx = bp[PHT_AW-1:0] ^ ghsr_m;
   ec   = pht_m[pidx];
   r = '0;
   r.is_bcc  = 1'b1;
   r.taken   = 1'b1;
   r.pc      = bp;
   r.npc_act = pc_t'(next_rand());
   r.upd     = upd[W-1];
   send_wb(r);
   @(negedge clk);
   check_value("echoed counter", 64'(sat_cnt(ec, 1'b1)),
               64'(dut0.bpu0.pht0.mem[pidx]));
   compare_tables();
   r = '0;
   r.is_breg = 1'b1;
   r.pc      = pc;
   r.npc_act = pc_t'(next_rand());
   send_wb(r);
   @(negedge clk);
   compare_tables();
   end_test("upd echo", e0);
endtask

// ==== tb/bpu_frontend_tb.sv ====
// Runs the front end with FW_P of 1 and checks every accepted bundle against
// a reference model of the tables and history. Reads DUT tables by hierarchy.
`timescale 1ns/100ps

module bpu_frontend_tb;

   import bpu_pkg::*;

   localparam int  FW_P         = 1;
   localparam int  W            = 1 << FW_P;
   localparam pc_t RESET_PC     = pc_t'('h100);
   localparam pc_t OFF_MASK     = pc_t'(W - 1);
   localparam int  ACCEPT_LIMIT = 64;
   // Rough cycle count of each test, in run order
   localparam int  TEST_CYCLES  = 10 + 40 + 300 + 20 + 210 + 40;

   logic                 clk;
   logic                 rst;
   logic                 out_valid;
   logic                 out_ready;
   pc_t                  out_pc;
   logic [W-1:0]         out_slot_valid;
   bpu_upd_t [W-1:0]     out_upd;
   pc_t                  out_npc;
   logic                 wb_valid;
   wb_rec_t              wb;

   // Reference model of tables and history
   pht_cnt_t             pht_m [1 << PHT_AW];
   btb_entry_t           btb_m [1 << BTB_AW];
   pht_idx_t             ghsr_m;
   // Model state seen by the lookup of the bundle on the outputs
   pht_cnt_t             snap_pht [1 << PHT_AW];
   btb_entry_t           snap_btb [1 << BTB_AW];
   pht_idx_t             snap_ghsr;

   pc_t                  exp_pc;
   logic                 redir_seen;
   logic                 hold_valid;
   pc_t                  held_pc;
   logic [W-1:0]         held_sv;
   pc_t                  held_npc;
   bpu_upd_t [W-1:0]     held_upd;

   int                   errors;
   int                   tests_run;
   int                   tests_failed;
   int                   accept_cnt;
   logic [31:0]          rnd_state;

   bpu_frontend
   #(
      .FW_P     (FW_P),
      .RESET_PC (RESET_PC)
   )
   dut0
   (
      .clk            (clk),
      .rst            (rst),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_pc         (out_pc),
      .out_slot_valid (out_slot_valid),
      .out_upd        (out_upd),
      .out_npc        (out_npc),
      .wb_valid       (wb_valid),
      .wb             (wb)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      #(TEST_CYCLES * 20 * 10);
      $display("Watchdog expired, the run took longer than %0d cycles", TEST_CYCLES * 20);
      $display("Result: FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rnd_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rnd_state = x;
      return x;
   endfunction

   function automatic pht_cnt_t sat_cnt(pht_cnt_t c, logic tk);
      if (tk)
         return (c == 2'b11) ? c : c + 2'b01;
      return (c == 2'b00) ? c : c - 2'b01;
   endfunction

   task automatic check_value(string name, logic [63:0] exp, logic [63:0] got);
      if (exp !== got)
      begin
         $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic complain(string msg);
      $display("ERROR t=%0t %s", $time, msg);
      errors++;
   endtask

   // Expected bundle from the start pc and the lookup-time model state
   task automatic check_bundle();
      pc_t        base;
      pc_t        off;
      pc_t        pc;
      pc_t        enpc;
      pht_idx_t   pidx;
      btb_idx_t   bidx;
      btb_entry_t e;
      pht_cnt_t   c;
      logic       tk;
      logic       seen;
      logic [W-1:0] esv;
      bpu_upd_t   eupd;
      base = exp_pc & ~OFF_MASK;
      off  = exp_pc & OFF_MASK;
      enpc = base + pc_t'(W);
      seen = 1'b0;
      check_value("out_pc", 64'(base), 64'(out_pc));
      for (int i = 0; i < W; i++)
      begin
         pc   = base + pc_t'(i);
         pidx = pc[PHT_AW-1:0] ^ snap_ghsr;
         bidx = pc[BTB_AW-1:0];
         e    = snap_btb[bidx];
         c    = snap_pht[pidx];
         tk   = (pc_t'(i) >= off) && e.valid && (e.tag == pc[PC_W-1:BTB_AW])
                && (!e.is_bcc || c[1]);
         esv[i] = (pc_t'(i) >= off) && !seen;
         if (tk && !seen)
            enpc = e.target;
         seen = seen || tk;
         eupd = '{cnt: c, pht_idx: pidx, btb_idx: bidx, tgt: e.target, taken: tk};
         check_value($sformatf("out_upd[%0d]", i), 64'(eupd), 64'(out_upd[i]));
      end
      check_value("out_slot_valid", 64'(esv), 64'(out_slot_valid));
      check_value("out_npc", 64'(enpc), 64'(out_npc));
      exp_pc = enpc;
   endtask

   // Monitor and model, all sampled at the rising edge
   always @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < (1 << PHT_AW); i++)
            pht_m[i] = PHT_CNT_INIT;
         for (int i = 0; i < (1 << BTB_AW); i++)
            btb_m[i] = '0;
         ghsr_m     = '0;
         exp_pc     = RESET_PC;
         redir_seen = 1'b0;
         hold_valid = 1'b0;
      end
      else
      begin
         if (redir_seen && out_valid)
            complain("bundle shown in the cycle after a mispredict");
         if (hold_valid && out_valid)
         begin
            check_value("stalled out_pc", 64'(held_pc), 64'(out_pc));
            check_value("stalled out_slot_valid", 64'(held_sv), 64'(out_slot_valid));
            check_value("stalled out_npc", 64'(held_npc), 64'(out_npc));
            if (held_upd !== out_upd)
               complain("out_upd changed during a stall");
         end
         if (out_valid && out_ready)
         begin
            accept_cnt++;
            check_bundle();
         end
         hold_valid = out_valid && !out_ready;
         held_pc    = out_pc;
         held_sv    = out_slot_valid;
         held_npc   = out_npc;
         held_upd   = out_upd;
         redir_seen = wb_valid && wb.mispredict;
         if (redir_seen)
            exp_pc = wb.npc_act;
         if (!out_valid || out_ready)
         begin
            snap_pht  = pht_m;
            snap_btb  = btb_m;
            snap_ghsr = ghsr_m;
         end
         if (wb_valid && wb.is_bcc)
         begin
            pht_m[wb.upd.pht_idx] = sat_cnt(wb.upd.cnt, wb.taken);
            ghsr_m = {ghsr_m[PHT_AW-2:0], wb.taken};
         end
         if (wb_valid && (wb.is_breg || wb.is_brel))
            btb_m[wb.pc[BTB_AW-1:0]] = '{valid: 1'b1, is_bcc: wb.is_bcc,
                                         tag: wb.pc[PC_W-1:BTB_AW], target: wb.npc_act};
      end
   end

   `include "bpu_frontend_tests.svh"

   initial
   begin
      rst          = 1'b1;
      out_ready    = 1'b1;
      wb_valid     = 1'b0;
      wb           = '0;
      rnd_state    = 32'hc5fc;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      accept_cnt   = 0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      reset_stream();
      btb_redirect();
      counter_saturation();
      mispredict_restart();
      random_stall();
      upd_echo();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== source/bpu_frontend.sv ====
// Write-back records are consumed in every cycle that wb_valid is high, and
// each must carry the out_upd record of its slot unchanged.
`timescale 1ns/100ps

module bpu_frontend
#(
   parameter int           FW_P     = 1,
   parameter bpu_pkg::pc_t RESET_PC = bpu_pkg::pc_t'('h100)
)
(
   input  logic                              clk,
   input  logic                              rst,
   output logic                              out_valid,
   input  logic                              out_ready,
   output bpu_pkg::pc_t                      out_pc,
   output logic [(1<<FW_P)-1:0]              out_slot_valid,
   output bpu_pkg::bpu_upd_t [(1<<FW_P)-1:0] out_upd,
   output bpu_pkg::pc_t                      out_npc,
   input  logic                              wb_valid,
   input  bpu_pkg::wb_rec_t                  wb
);

   import bpu_pkg::*;

   localparam int W = 1 << FW_P;

   logic         re;
   pc_t [W-1:0]  pc_slots;
   logic [W-1:0] slot_valid;
   pc_t [W-1:0]  npc;
   logic [W-1:0] taken;

   fetch_ctrl
   #(
      .FW_P     (FW_P),
      .RESET_PC (RESET_PC)
   )
   fetch_ctrl0
   (
      .clk            (clk),
      .rst            (rst),
      .re             (re),
      .pc_slots       (pc_slots),
      .slot_valid     (slot_valid),
      .npc            (npc),
      .taken          (taken),
      .wb_valid       (wb_valid),
      .wb             (wb),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_pc         (out_pc),
      .out_slot_valid (out_slot_valid),
      .out_npc        (out_npc)
   );

   bpu
   #(
      .FW_P (FW_P)
   )
   bpu0
   (
      .clk        (clk),
      .rst        (rst),
      .re         (re),
      .slot_valid (slot_valid),
      .pc_slots   (pc_slots),
      .npc        (npc),
      .taken      (taken),
      .upd        (out_upd),
      .wb_valid   (wb_valid),
      .wb         (wb)
   );

endmodule

// ==== source/fetch_ctrl.sv ====
// Bundles are aligned to 2**FW_P words. A mispredict write-back beats any
// predicted redirect and leaves the output empty for one cycle.
`timescale 1ns/100ps

module fetch_ctrl
#(
   parameter int           FW_P     = 1,
   parameter bpu_pkg::pc_t RESET_PC = '0
)
(
   input  logic                         clk,
   input  logic                         rst,
   output logic                         re,
   output bpu_pkg::pc_t [(1<<FW_P)-1:0] pc_slots,
   output logic [(1<<FW_P)-1:0]         slot_valid,
   input  bpu_pkg::pc_t [(1<<FW_P)-1:0] npc,
   input  logic [(1<<FW_P)-1:0]         taken,
   input  logic                         wb_valid,
   input  bpu_pkg::wb_rec_t             wb,
   output logic                         out_valid,
   input  logic                         out_ready,
   output bpu_pkg::pc_t                 out_pc,
   output logic [(1<<FW_P)-1:0]         out_slot_valid,
   output bpu_pkg::pc_t                 out_npc
);

   import bpu_pkg::*;

   localparam int  W        = 1 << FW_P;
   localparam pc_t OFF_MASK = pc_t'(W - 1);

   pc_t          fetch_pc;
   pc_t          s0_pc;
   pc_t          s0_base;
   pc_t          s0_off;
   pc_t          s1_base;
   logic [W-1:0] s1_mask;
   logic         taken_seen;
   logic         redirect;

   assign redirect = wb_valid && wb.mispredict;

   // Stage 1 advances when empty or when its bundle is accepted
   assign re = !out_valid || out_ready;

   // Chain from the bundle on the output, else restart at fetch_pc
   assign s0_pc   = out_valid ? out_npc : fetch_pc;
   assign s0_base = s0_pc & ~OFF_MASK;
   assign s0_off  = s0_pc & OFF_MASK;

   // Slots below the entry offset are not fetched
   always_comb
   begin
      for (int i = 0; i < W; i++)
      begin
         pc_slots[i]   = s0_base + pc_t'(i);
         slot_valid[i] = pc_t'(i) >= s0_off;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_pc <= RESET_PC;
      else if (redirect)
         fetch_pc <= wb.npc_act;
   end

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         s1_base <= s0_base;
         s1_mask <= slot_valid;
      end
   end

   // Redirect drops the bundle in flight
   always_ff @(posedge clk)
   begin
      if (rst || redirect)
         out_valid <= 1'b0;
      else if (re)
         out_valid <= 1'b1;
   end

   // First taken slot wins and clears the slots after it
   always_comb
   begin
      taken_seen = 1'b0;
      out_npc    = s1_base + pc_t'(W);
      for (int i = 0; i < W; i++)
      begin
         out_slot_valid[i] = s1_mask[i] && !taken_seen;
         if (taken[i] && !taken_seen)
         begin
            out_npc = npc[i];
         end
         taken_seen = taken_seen || taken[i];
      end
   end

   assign out_pc = s1_base;

endmodule

// ==== source/bpu.sv ====
// gshare direction predictor with a direct-mapped BTB. History moves only on
// resolved conditional branches and is never repaired speculatively.
`timescale 1ns/100ps

module bpu
#(
   parameter int FW_P = 1
)
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              re,
   input  logic [(1<<FW_P)-1:0]              slot_valid,
   input  bpu_pkg::pc_t [(1<<FW_P)-1:0]      pc_slots,
   output bpu_pkg::pc_t [(1<<FW_P)-1:0]      npc,
   output logic [(1<<FW_P)-1:0]              taken,
   output bpu_pkg::bpu_upd_t [(1<<FW_P)-1:0] upd,
   input  logic                              wb_valid,
   input  bpu_pkg::wb_rec_t                  wb
);

   import bpu_pkg::*;

   localparam int W = 1 << FW_P;

   // Indexes formed from the stage-0 pcs
   pht_idx_t [W-1:0]   s1i_pht_idx;
   btb_idx_t [W-1:0]   s1i_btb_idx;

   // Stage-1 registers, loaded with the table read
   pc_t [W-1:0]        s1_pc;
   pht_idx_t [W-1:0]   s1_pht_idx;
   btb_idx_t [W-1:0]   s1_btb_idx;
   logic [W-1:0]       s1_valid;

   pht_cnt_t [W-1:0]   pht_rd;
   btb_entry_t [W-1:0] btb_rd;
   logic [W-1:0]       hit;

   logic               pht_we;
   pht_cnt_t           pht_wdata;
   logic               btb_we;
   btb_idx_t           btb_waddr;
   btb_entry_t         btb_wdata;
   pht_idx_t           ghsr;

   always_comb
   begin
      for (int i = 0; i < W; i++)
      begin
         s1i_pht_idx[i] = pc_slots[i][PHT_AW-1:0] ^ ghsr;
         s1i_btb_idx[i] = pc_slots[i][BTB_AW-1:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         s1_pc      <= pc_slots;
         s1_pht_idx <= s1i_pht_idx;
         s1_btb_idx <= s1i_btb_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         s1_valid <= '0;
      else if (re)
         s1_valid <= slot_valid;
   end

   pred_table
   #(
      .entry_t   (pht_cnt_t),
      .AW        (PHT_AW),
      .NUM_READ  (W),
      .RESET_VAL (PHT_CNT_INIT)
   )
   pht0
   (
      .clk   (clk),
      .rst   (rst),
      .re    ({W{re}}),
      .raddr (s1i_pht_idx),
      .rdata (pht_rd),
      .we    (pht_we),
      .waddr (wb.upd.pht_idx),
      .wdata (pht_wdata)
   );

   pred_table
   #(
      .entry_t   (btb_entry_t),
      .AW        (BTB_AW),
      .NUM_READ  (W),
      .RESET_VAL (BTB_ENTRY_INIT)
   )
   btb0
   (
      .clk   (clk),
      .rst   (rst),
      .re    ({W{re}}),
      .raddr (s1i_btb_idx),
      .rdata (btb_rd),
      .we    (btb_we),
      .waddr (btb_waddr),
      .wdata (btb_wdata)
   );

   // Hit needs a valid entry with matching tag
   // unconditional jumps ignore the counter
   always_comb
   begin
      for (int i = 0; i < W; i++)
      begin
         hit[i]   = btb_rd[i].valid && (btb_rd[i].tag == s1_pc[i][PC_W-1:BTB_AW]);
         taken[i] = s1_valid[i] && hit[i] && (!btb_rd[i].is_bcc || pht_rd[i][1]);
         npc[i]   = btb_rd[i].target;

         upd[i].cnt     = pht_rd[i];
         upd[i].pht_idx = s1_pht_idx[i];
         upd[i].btb_idx = s1_btb_idx[i];
         upd[i].tgt     = btb_rd[i].target;
         upd[i].taken   = taken[i];
      end
   end

   assign pht_we = wb_valid && wb.is_bcc;
   assign btb_we = wb_valid && (wb.is_breg || wb.is_brel);

   // Counter steps from the value seen at lookup time
   always_comb
   begin
      if (wb.taken)
         pht_wdata = (wb.upd.cnt == 2'b11) ? 2'b11 : wb.upd.cnt + 2'b01;
      else
         pht_wdata = (wb.upd.cnt == 2'b00) ? 2'b00 : wb.upd.cnt - 2'b01;
   end

   assign btb_waddr = wb.pc[BTB_AW-1:0];

   always_comb
   begin
      btb_wdata.valid  = 1'b1;
      btb_wdata.is_bcc = wb.is_bcc;
      btb_wdata.tag    = wb.pc[PC_W-1:BTB_AW];
      btb_wdata.target = wb.npc_act;
   end

   // Newest outcome enters at bit 0
   always_ff @(posedge clk)
   begin
      if (rst)
         ghsr <= '0;
      else if (pht_we)
         ghsr <= {ghsr[PHT_AW-2:0], wb.taken};
   end

endmodule

// ==== source/pred_table.sv ====
// Flop table with one registered data port per reader. A read in the cycle
// of a write returns the old entry, and read data holds while re is low.
`timescale 1ns/100ps

module pred_table
#(
   parameter type    entry_t   = logic [1:0],
   parameter int     AW        = 4,
   parameter int     NUM_READ  = 1,
   parameter entry_t RESET_VAL = '0
)
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [NUM_READ-1:0]         re,
   input  logic [NUM_READ-1:0][AW-1:0] raddr,
   output entry_t [NUM_READ-1:0]       rdata,
   input  logic                        we,
   input  logic [AW-1:0]               waddr,
   input  entry_t                      wdata
);

   localparam int DEPTH = 1 << AW;

   entry_t mem [DEPTH];

   // Every entry back to its initial value on reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            mem[i] <= RESET_VAL;
         end
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int p = 0; p < NUM_READ; p++)
      begin
         if (re[p])
         begin
            rdata[p] <= mem[raddr[p]];
         end
      end
   end

endmodule

// ==== source/bpu_pkg.sv ====
// Word addresses with one instruction per word. Table geometry is fixed here
// because the update record and the BTB entry carry index and tag fields.
package bpu_pkg;

   localparam int PC_W = 30;

   typedef logic [PC_W-1:0] pc_t;

   // Upper bound for any PHT index width
   localparam int PHT_AW_MAX = 16;
   localparam int PHT_AW     = (8 < PHT_AW_MAX) ? 8 : PHT_AW_MAX;

   typedef logic [PHT_AW-1:0] pht_idx_t;

   // Direct-mapped BTB, tag is the pc above the index
   localparam int BTB_AW    = 6;
   localparam int BTB_TAG_W = PC_W - BTB_AW;

   typedef logic [BTB_AW-1:0]    btb_idx_t;
   typedef logic [BTB_TAG_W-1:0] btb_tag_t;

   // Bit 1 set predicts taken
   typedef logic [1:0] pht_cnt_t;

   // Weakly not taken
   localparam pht_cnt_t PHT_CNT_INIT = 2'b01;

   typedef struct packed {
      logic     valid;
      logic     is_bcc;
      btb_tag_t tag;
      pc_t      target;
   } btb_entry_t;

   localparam btb_entry_t BTB_ENTRY_INIT = '0;

   // Per-slot state captured at lookup and returned with the resolved branch
   typedef struct packed {
      pht_cnt_t cnt;
      pht_idx_t pht_idx;
      btb_idx_t btb_idx;
      pc_t      tgt;
      logic     taken;
   } bpu_upd_t;

   typedef struct packed {
      logic     is_bcc;
      logic     is_breg;
      logic     is_brel;
      logic     taken;
      pc_t      pc;
      pc_t      npc_act;
      logic     mispredict;
      bpu_upd_t upd;
   } wb_rec_t;

endpackage
